//--- verilog.f
+incdir+src
src/decode_pkg.sv
src/insn_cracker.sv
src/uop_packer.sv
src/credit_counter.sv
src/decode_stage_reg.sv
src/decode_top.sv
bench/decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= decode_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SRCS := src/decode_macros.svh $(filter-out +%,$(shell cat verilog.f))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): verilog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/decode_tb.sv
`include "decode_macros.svh"

module decode_tb
  import decode_pkg::*;
;
  typedef struct packed {
    uop_t [`UQ_WIDTH-1:0] uops;
    logic [2:0]           count;
  } bundle_t;

  logic                   clk_in;
  logic                   reset;
  logic                   flush;
  logic                   fetch_valid;
  logic                   credit_return;
  logic [`INSN_WIDTH-1:0] fetch_insns [`FETCH_WIDTH];
  logic [`PC_WIDTH-1:0]   fetch_pc;
  logic                   decode_ready;
  logic                   out_valid;
  uop_t                   out_uops [`UQ_WIDTH];
  logic [2:0]             out_count;

  logic [31:0] lfsr = 32'h629ad648;
  bundle_t     exp_q [$];
  string       name_q [$];
  string       test_name;
  bit          withhold;
  int          errors, err_mark, tests_run, tests_failed;
  int          issued, cycles, owed, sent_total, returned_total;

  decode_top decode_top_inst (
    .clk_in(clk_in), .reset(reset), .flush(flush), .fetch_valid(fetch_valid),
    .fetch_insns(fetch_insns), .fetch_pc(fetch_pc), .credit_return(credit_return),
    .decode_ready(decode_ready), .out_valid(out_valid), .out_uops(out_uops),
    .out_count(out_count)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > 40 * issued + 200) begin
      $display("timeout: run did not finish within %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] rand_alu();
    logic [7:0] ops [9] = '{8'h10, 8'h11, 8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h30, 8'h31};
    int         idx;
    idx = int'(rand_bits(4) % 9);
    return {ops[idx], 24'(rand_bits(24))};
  endfunction

  function automatic logic [31:0] rand_mem(input bit zero_off);
    logic [31:0] w;
    w = {8'h40 | 8'(rand_bits(1)), 24'(rand_bits(24))};
    if (zero_off) w[20:12] = '0;
    else w[12] = 1'b1;
    return w;
  endfunction

  // expected bundle straight from the encoding rules
  function automatic bundle_t ref_decode(input logic [31:0] i0, input logic [31:0] i1,
                                         input logic [31:0] pc);
    bundle_t     b;
    logic [31:0] insn;
    logic [31:0] spc;
    logic [7:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rn;
    logic [8:0]  off;
    logic        ld;
    logic        halted;
    uop_code_e   code;
    int          n;
    b = '0;
    n = 0;
    halted = 1'b0;
    for (int s = 0; s < `FETCH_WIDTH && !halted; s++) begin
      insn = (s == 0) ? i0 : i1;
      spc  = pc + 32'(4 * s);
      op   = insn[31:24];
      rd   = insn[4:0];
      rn   = insn[9:5];
      off  = insn[20:12];
      ld   = (op == 8'h40);
      case (op)
        8'h11, 8'h21: code = UOP_SUB;
        8'h22:        code = UOP_ORR;
        8'h23:        code = UOP_EOR;
        8'h24:        code = UOP_AND;
        8'h30:        code = UOP_MOVZ;
        8'h31:        code = UOP_MOVK;
        8'h40:        code = UOP_LOAD;
        8'h41:        code = UOP_STORE;
        default:      code = UOP_ADD;
      endcase
      case (op)
        8'h10, 8'h11: begin
          b.uops[n] = '{code, rd, rn, {7'd0, insn[21:10], 2'd0}, 0, 0, 0, 1, 1, 1, spc};
          n += 1;
        end
        8'h20, 8'h21, 8'h22, 8'h23, 8'h24: begin
          b.uops[n] = '{code, rd, rn, {16'd0, insn[20:16]}, 1, 0, 0, 1, 1, 1, spc};
          n += 1;
        end
        8'h30, 8'h31: begin
          b.uops[n] = '{code, rd, 5'd0, {3'd0, insn[20:5], insn[22:21]}, 0, 0, 0, 1, 1, 1, spc};
          n += 1;
        end
        8'h40, 8'h41: begin
          if (off == 9'd0) begin
            b.uops[n] = '{code, rd, rn, 21'd0, 0, ld, !ld, ld, 1, 1, spc};
            n += 1;
          end else begin
            b.uops[n] = '{UOP_ADD, 5'(`SCRATCH_REG), rn, {10'd0, off, 2'd0}, 0, 0, 0, 1, 1, 0, spc};
            b.uops[n+1] = '{code, rd, 5'(`SCRATCH_REG), 21'd0, 0, ld, !ld, ld, 0, 1, spc};
            n += 2;
          end
        end
        8'h01: begin
          b.uops[n] = '{UOP_HLT, 5'd0, 5'd0, 21'd0, 0, 0, 0, 0, 1, 1, spc};
          n += 1;
          halted = 1'b1;
        end
        default: ;
      endcase
    end
    b.count = 3'(n);
    return b;
  endfunction

  task automatic issue(input logic [31:0] i0, input logic [31:0] i1);
    bundle_t e;
    fetch_pc       = rand_bits(30) << 2;
    fetch_insns[0] = i0;
    fetch_insns[1] = i1;
    fetch_valid    = 1'b1;
    issued++;
    @(negedge clk_in);
    while (!decode_ready) @(negedge clk_in);
    e = ref_decode(i0, i1, fetch_pc);
    if (e.count != 3'd0) begin
      exp_q.push_back(e);
      name_q.push_back(test_name);
    end
    @(posedge clk_in);
    #2;
    fetch_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || owed != 0) @(posedge clk_in);
    #2;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %s: fail", test_name);
    end else begin
      $display("test %s: ok", test_name);
    end
    err_mark = errors;
  endtask

  // consumer, gives each credit back after 0 to 7 cycles
  initial begin
    int   wait_cnt;
    logic ret;
    credit_return = 1'b0;
    owed = 0;
    wait_cnt = 0;
    forever begin
      @(negedge clk_in);
      if (out_valid) owed += int'(out_count);
      ret = 1'b0;
      if (!withhold && owed > 0) begin
        if (wait_cnt == 0) begin
          ret = 1'b1;
          owed--;
          wait_cnt = int'(rand_bits(3));
        end else begin
          wait_cnt--;
        end
      end
      @(posedge clk_in);
      #2;
      credit_return = ret;
    end
  end

  always @(negedge clk_in) begin
    bundle_t e;
    string   nm;
    if (credit_return) returned_total++;
    if (out_valid && exp_q.size() == 0) begin
      $display("bundle sent while none was expected during %s", test_name);
      errors++;
    end else if (out_valid) begin
      e  = exp_q.pop_front();
      nm = name_q.pop_front();
      sent_total += int'(out_count);
      assert (sent_total <= `CREDIT_MAX + returned_total) else begin
        $display("%s: %0d uops sent with only %0d credits returned", nm, sent_total,
                 returned_total);
        errors++;
      end
      assert (out_count == e.count) else begin
        $display("[ERROR] %s count: expected %0d actual %0d", nm, e.count, out_count);
        errors++;
      end
      for (int k = 0; k < `UQ_WIDTH; k++) begin
        assert (out_uops[k] == e.uops[k]) else begin
          $display("[ERROR] %s uop %0d: expected %h actual %h", nm, k, e.uops[k], out_uops[k]);
          errors++;
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_insns = '{default: '0};
    withhold = 1'b0;
    test_name = "reset";
    repeat (2) begin
      @(negedge clk_in);
      assert (!out_valid && !decode_ready) else begin
        $display("decode outputs active while in reset");
        errors++;
      end
    end
    @(posedge clk_in);
    #2;
    reset = 1'b0;
    @(posedge clk_in);
    @(negedge clk_in);
    assert (decode_ready && !out_valid) else begin
      $display("decode_ready not high in the first cycle after reset");
      errors++;
    end
    @(posedge clk_in);
    #2;
    finish_test();

    test_name = "alu_mov";
    repeat (12) issue(rand_alu(), rand_alu());
    drain();
    finish_test();

    test_name = "ldur_stur";
    repeat (12) issue(rand_mem(1'(rand_bits(1))), rand_mem(1'(rand_bits(1))));
    drain();
    finish_test();

    test_name = "halt_nop";
    issue({8'h01, 24'(rand_bits(24))}, rand_alu());
    issue({8'h00, 24'(rand_bits(24))}, rand_alu());
    issue({8'h7f, 24'(rand_bits(24))}, {8'h00, 24'(rand_bits(24))});
    issue({8'h00, 24'(rand_bits(24))}, {8'h55, 24'(rand_bits(24))});
    repeat (10) @(posedge clk_in);
    #2;
    drain();
    finish_test();

    test_name = "credit_stall";
    withhold = 1'b1;
    repeat (3) issue(rand_mem(1'b0), rand_mem(1'b0));
    repeat (20) @(posedge clk_in);
    #2;
    assert (exp_q.size() == 1) else begin
      $display("held bundle was sent while execute had no credits");
      errors++;
    end
    withhold = 1'b0;
    drain();
    finish_test();

    test_name = "flush";
    withhold = 1'b1;
    repeat (3) issue(rand_mem(1'b0), rand_mem(1'b0));
    flush = 1'b1;
    void'(exp_q.pop_back());   // the held bundle is dropped
    void'(name_q.pop_back());
    @(posedge clk_in);
    #2;
    flush = 1'b0;
    withhold = 1'b0;
    repeat (2) issue(rand_alu(), rand_mem(1'(rand_bits(1))));
    drain();
    finish_test();

    if (exp_q.size() != 0) begin
      $display("%0d expected bundles never arrived", exp_q.size());
      errors++;
    end
    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src/decode_top.sv
`include "decode_macros.svh"

module decode_top
  import decode_pkg::*;
(
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   fetch_valid,
  input  logic [`INSN_WIDTH-1:0] fetch_insns [`FETCH_WIDTH],
  input  logic [`PC_WIDTH-1:0]   fetch_pc,
  input  logic                   credit_return,
  output logic                   decode_ready,
  output logic                   out_valid,
  output uop_t                   out_uops [`UQ_WIDTH],
  output logic [2:0]             out_count
);
  uop_t                    slot_uop_a [`FETCH_WIDTH];
  uop_t                    slot_uop_b [`FETCH_WIDTH];
  logic [1:0]              slot_count [`FETCH_WIDTH];
  logic [`FETCH_WIDTH-1:0] slot_halt;
  uop_t                    packed_uops [`UQ_WIDTH];
  logic [2:0]              packed_count;
  logic [3:0]              credits;
  logic                    spend;

  for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gen_slot
    logic [`PC_WIDTH-1:0] slot_pc;

    assign slot_pc = fetch_pc + `PC_WIDTH'(4 * i);   // word per slot

    insn_cracker cracker_inst (
      .insn      (fetch_insns[i]),
      .pc        (slot_pc),
      .uop_a     (slot_uop_a[i]),
      .uop_b     (slot_uop_b[i]),
      .uop_count (slot_count[i]),
      .halt      (slot_halt[i])
    );
  end

  uop_packer packer_inst (
    .slot_uop_a   (slot_uop_a),
    .slot_uop_b   (slot_uop_b),
    .slot_count   (slot_count),
    .slot_halt    (slot_halt),
    .packed_uops  (packed_uops),
    .packed_count (packed_count)
  );

  credit_counter credit_inst (
    .clk_in        (clk_in),
    .reset         (reset),
    .credit_return (credit_return),
    .spend         (spend),
    .spend_count   (out_count),
    .credits       (credits)
  );

  decode_stage_reg stage_inst (
    .clk_in       (clk_in),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .decode_ready (decode_ready),
    .in_uops      (packed_uops),
    .in_count     (packed_count),
    .credits      (credits),
    .spend        (spend),
    .out_valid    (out_valid),
    .out_uops     (out_uops),
    .out_count    (out_count)
  );

endmodule

//--- src/decode_stage_reg.sv
`include "decode_macros.svh"

module decode_stage_reg
  import decode_pkg::*;
(
  input  logic       clk_in,
  input  logic       reset,
  input  logic       flush,
  input  logic       fetch_valid,
  output logic       decode_ready,
  input  uop_t       in_uops [`UQ_WIDTH],
  input  logic [2:0] in_count,
  input  logic [3:0] credits,
  output logic       spend,
  output logic       out_valid,
  output uop_t       out_uops [`UQ_WIDTH],
  output logic [2:0] out_count
);
  logic running;   // low while in reset, high from the first cycle after
  logic held;
  logic accept;

  assign out_valid    = held && !flush && ({1'b0, out_count} <= credits);
  assign spend        = out_valid;
  assign decode_ready = running && !flush && (!held || out_valid);
  assign accept       = fetch_valid && decode_ready;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      running <= 1'b0;
      held    <= 1'b0;
    end else begin
      running <= 1'b1;
      if (flush) begin
        held <= 1'b0;
      end else if (accept) begin
        held <= (in_count != 3'd0);   // empty bundles are dropped here
      end else if (out_valid) begin
        held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept && in_count != 3'd0) begin
      out_uops  <= in_uops;
      out_count <= in_count;
    end
  end

  // a bundle starved of credit stays put until sent or flushed
  assert property (@(posedge clk_in) disable iff (reset)
    held && !out_valid && !flush |=> held && $stable(out_count))
    else $error("held bundle of %0d lost while waiting for credit", out_count);

endmodule

//--- src/credit_counter.sv
`include "decode_macros.svh"

module credit_counter (
  input  logic       clk_in,
  input  logic       reset,
  input  logic       credit_return,
  input  logic       spend,
  input  logic [2:0] spend_count,
  output logic [3:0] credits
);
  logic [3:0] spent;

  assign spent = spend ? 4'(spend_count) : 4'd0;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      credits <= 4'(`CREDIT_MAX);   // execute queue starts empty
    end else begin
      credits <= credits + 4'(credit_return) - spent;
    end
  end

  // consumer may not hand back more than it was given
  assert property (@(posedge clk_in) disable iff (reset)
    credits <= 4'(`CREDIT_MAX))
    else $error("credit count above max: %0d", credits);

  // stage must never send without enough credit
  assert property (@(posedge clk_in) disable iff (reset)
    spend |-> ({1'b0, spend_count} <= credits))
    else $error("spend of %0d with only %0d credits", spend_count, credits);

endmodule

//--- src/uop_packer.sv
`include "decode_macros.svh"

module uop_packer
  import decode_pkg::*;
(
  input  uop_t                    slot_uop_a [`FETCH_WIDTH],
  input  uop_t                    slot_uop_b [`FETCH_WIDTH],
  input  logic [1:0]              slot_count [`FETCH_WIDTH],
  input  logic [`FETCH_WIDTH-1:0] slot_halt,
  output uop_t                    packed_uops [`UQ_WIDTH],
  output logic [2:0]              packed_count
);
  localparam int IDX_W = $clog2(`UQ_WIDTH);

  always_comb begin
    logic [2:0] idx;
    logic       done;
    packed_uops = '{default: '0};
    idx         = 3'd0;
    done        = 1'b0;
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      if (!done) begin
        if (slot_count[s] != 2'd0) begin
          packed_uops[IDX_W'(idx)] = slot_uop_a[s];
        end
        if (slot_count[s] == 2'd2) begin
          packed_uops[IDX_W'(idx + 3'd1)] = slot_uop_b[s];
        end
        idx  = idx + 3'(slot_count[s]);
        done = slot_halt[s];   // later slots are dropped after hlt
      end
    end
    packed_count = idx;
  end

  // every slot cracking to two uops must still fit the bundle
  assert property (@(packed_count) packed_count <= 3'(`UQ_WIDTH))
    else $error("packed bundle overflows uq: %0d", packed_count);

endmodule

//--- src/insn_cracker.sv
`include "decode_macros.svh"

module insn_cracker
  import decode_pkg::*;
(
  input  logic [`INSN_WIDTH-1:0] insn,
  input  logic [`PC_WIDTH-1:0]   pc,
  output uop_t                   uop_a,
  output uop_t                   uop_b,
  output logic [1:0]             uop_count,
  output logic                   halt
);
  op_code_e                  opcode;
  uop_code_e                 alu_code;
  logic [`REG_IDX_WIDTH-1:0] rd;
  logic [`REG_IDX_WIDTH-1:0] rn;
  logic [`REG_IDX_WIDTH-1:0] rm;
  logic [8:0]                mem_off;
  logic                      is_load;
  uop_t                      blank;
  uop_t                      mem_uop;

  assign opcode  = op_code_e'(insn[31:24]);
  assign rd      = insn[4:0];
  assign rn      = insn[9:5];
  assign rm      = insn[20:16];
  assign mem_off = insn[20:12];
  assign is_load = (opcode == OP_LDUR);

  always_comb begin
    case (opcode)
      OP_SUB_RI, OP_SUB_RR: alu_code = UOP_SUB;
      OP_ORR_RR:            alu_code = UOP_ORR;
      OP_EOR_RR:            alu_code = UOP_EOR;
      OP_AND_RR:            alu_code = UOP_AND;
      default:              alu_code = UOP_ADD;
    endcase
  end

  always_comb begin
    blank          = '0;
    blank.pc       = pc;
    blank.tx_begin = 1'b1;
    blank.tx_end   = 1'b1;

    // memory half, reads the scratch reg when an add goes in front
    mem_uop           = blank;
    mem_uop.uopcode   = is_load ? UOP_LOAD : UOP_STORE;
    mem_uop.dst       = rd;
    mem_uop.src1      = (mem_off == '0) ? rn : `REG_IDX_WIDTH'(`SCRATCH_REG);
    mem_uop.mem_read  = is_load;
    mem_uop.mem_write = !is_load;
    mem_uop.w_enable  = is_load;
    mem_uop.tx_begin  = (mem_off == '0);
  end

  always_comb begin
    uop_a     = '0;
    uop_b     = '0;
    uop_count = 2'd0;
    halt      = 1'b0;
    case (opcode)
      OP_ADD_RI, OP_SUB_RI: begin
        uop_a                     = blank;
        uop_a.uopcode             = alu_code;
        uop_a.dst                 = rd;
        uop_a.src1                = rn;
        uop_a.payload.ri_view.imm = 19'(insn[21:10]);   // zero-extended
        uop_a.w_enable            = 1'b1;
        uop_count                 = 2'd1;
      end
      OP_ADD_RR, OP_SUB_RR, OP_ORR_RR, OP_EOR_RR, OP_AND_RR: begin
        uop_a                      = blank;
        uop_a.uopcode              = alu_code;
        uop_a.dst                  = rd;
        uop_a.src1                 = rn;
        uop_a.payload.rr_view.src2 = rm;
        uop_a.valb_sel             = 1'b1;
        uop_a.w_enable             = 1'b1;
        uop_count                  = 2'd1;
      end
      OP_MOVZ, OP_MOVK: begin
        uop_a                     = blank;   // no source register
        uop_a.uopcode             = (opcode == OP_MOVK) ? UOP_MOVK : UOP_MOVZ;
        uop_a.dst                 = rd;
        uop_a.payload.ri_view.imm = 19'(insn[20:5]);
        uop_a.payload.ri_view.hw  = insn[22:21];
        uop_a.w_enable            = 1'b1;
        uop_count                 = 2'd1;
      end
      OP_LDUR, OP_STUR: begin
        if (mem_off == '0) begin
          uop_a     = mem_uop;
          uop_count = 2'd1;
        end else begin
          uop_a                     = blank;
          uop_a.uopcode             = UOP_ADD;
          uop_a.dst                 = `REG_IDX_WIDTH'(`SCRATCH_REG);
          uop_a.src1                = rn;
          uop_a.payload.ri_view.imm = 19'(mem_off);
          uop_a.w_enable            = 1'b1;
          uop_a.tx_end              = 1'b0;   // pair closes on the memory op
          uop_b                     = mem_uop;
          uop_count                 = 2'd2;
        end
      end
      OP_HLT: begin
        uop_a         = blank;
        uop_a.uopcode = UOP_HLT;
        uop_count     = 2'd1;
        halt          = 1'b1;
      end
      default: ;   // nop and unknown opcodes emit nothing
    endcase
  end

endmodule

//--- src/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

  // opcode lives in insn[31:24]
  typedef enum logic [7:0] {
    OP_NOP    = 8'h00,
    OP_HLT    = 8'h01,
    OP_ADD_RI = 8'h10,
    OP_SUB_RI = 8'h11,
    OP_ADD_RR = 8'h20,
    OP_SUB_RR = 8'h21,
    OP_ORR_RR = 8'h22,
    OP_EOR_RR = 8'h23,
    OP_AND_RR = 8'h24,
    OP_MOVZ   = 8'h30,
    OP_MOVK   = 8'h31,
    OP_LDUR   = 8'h40,
    OP_STUR   = 8'h41
  } op_code_e;

  typedef enum logic [3:0] {
    UOP_NOP, UOP_ADD, UOP_SUB, UOP_ORR, UOP_EOR, UOP_AND,
    UOP_MOVZ, UOP_MOVK, UOP_LOAD, UOP_STORE, UOP_HLT
  } uop_code_e;

  typedef struct packed {
    logic [20-`REG_IDX_WIDTH:0] pad;
    logic [`REG_IDX_WIDTH-1:0]  src2;
  } rr_view_t;

  typedef struct packed {
    logic [18:0] imm;
    logic [1:0]  hw;   // half-word shift for moves
  } ri_view_t;

  // valb_sel picks which view execute reads
  typedef union packed {
    rr_view_t rr_view;
    ri_view_t ri_view;
  } uop_payload_u;

  typedef struct packed {
    uop_code_e                 uopcode;
    logic [`REG_IDX_WIDTH-1:0] dst;
    logic [`REG_IDX_WIDTH-1:0] src1;
    uop_payload_u              payload;
    logic                      valb_sel;
    logic                      mem_read;
    logic                      mem_write;
    logic                      w_enable;
    logic                      tx_begin;
    logic                      tx_end;
    logic [`PC_WIDTH-1:0]      pc;
  } uop_t;

endpackage

//--- src/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// instructions per fetch bundle
`define FETCH_WIDTH 2
// micro-ops per bundle sent to execute
`define UQ_WIDTH 4

`define INSN_WIDTH 32
`define PC_WIDTH 32
`define REG_IDX_WIDTH 5

// entries in the execute queue, one credit each
`define CREDIT_MAX 8

// holds the computed address of a cracked ldur/stur
`define SCRATCH_REG 31

`endif
